//--- all.f
+incdir+include
source/audio_pkg.sv
source/audio_attenuate.sv
source/audio_sum.sv
source/audio_level.sv
source/audio_compress.sv
source/audio_mixer.sv
tb/tb_clock.sv
tb/tb_audio_mixer.sv

//--- include/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// Sample and accumulator widths
`define AUDIO_W 16
`define AUDIO_ACC_W 18

//////////////////////////////////////////////////
// Compressor curves
//////////////////////////////////////////////////

// Curve 1, 2x gain below the knee
`define COMP1_A 2
`define COMP1_F 4
`define COMP1_X 14044
`define COMP1_B 28088

// Curve 2, 4x gain below the knee
`define COMP2_A 4
`define COMP2_F 8
`define COMP2_X 7400
`define COMP2_B 29600

// Input to output, in clk_sys cycles
`define MIX_LATENCY 4

`endif

//--- run.sh
#!/bin/sh
# Build and run the audio mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_audio_mixer -Mdir obj_dir -o tb_audio_mixer -f all.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/tb_audio_mixer > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- source/audio_attenuate.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_attenuate (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  audio_pkg::src_sample_t src,
	input  audio_pkg::mix_mode_t   mode,
	output audio_pkg::atten_sample_t out
);

	//////////////////////////////////////////////////
	// Gain terms
	//////////////////////////////////////////////////

	// PSG gain 1/2 + 1/4 + 1/16 = 13/16
	function automatic logic signed [`AUDIO_W-1:0] psg_gain(
		input logic signed [`AUDIO_W-1:0] s
	);
		psg_gain = (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// ADPCM gain 1/2 + 1/4 + 1/8 = 7/8
	function automatic logic signed [`AUDIO_W-1:0] adpcm_gain(
		input logic signed [`AUDIO_W-1:0] s
	);
		adpcm_gain = (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	// Stage 1 register, mode captured alongside its sample
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out <= '0;
		end else begin
			out.cdda_l <= src.cdda_l;
			out.cdda_r <= src.cdda_r;
			out.psg_l  <= psg_gain($signed(src.psg_l));
			out.psg_r  <= psg_gain($signed(src.psg_r));
			out.adpcm  <= adpcm_gain($signed(src.adpcm));
			out.mode   <= mode;
		end
	end

endmodule

//--- source/audio_compress.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_compress (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  audio_pkg::level_sample_t  in,
	output logic signed [`AUDIO_W-1:0] audio_l,
	output logic signed [`AUDIO_W-1:0] audio_r
);

	//////////////////////////////////////////////////
	// Compressor curves
	//////////////////////////////////////////////////

	// Linear gain below the knee, shallow slope above it
	function automatic logic [`AUDIO_W-1:0] curve(
		input logic [`AUDIO_W-1:0] v,
		input logic [`AUDIO_W-1:0] x,
		input logic [`AUDIO_W-1:0] a,
		input logic [`AUDIO_W-1:0] f,
		input logic [`AUDIO_W-1:0] b
	);
		if (v < x)
			curve = v * a;
		else
			curve = ((v - x) / f) + b;
	endfunction

	// Works on the magnitude, sign restored afterwards
	function automatic logic [`AUDIO_W-1:0] compress(
		input logic [`AUDIO_W-1:0] s,
		input logic                use_4x
	);
		logic [`AUDIO_W-1:0] mag;
		logic [`AUDIO_W-1:0] res_2x;
		logic [`AUDIO_W-1:0] res_4x;
		logic [`AUDIO_W-1:0] res;
		mag = s[`AUDIO_W-1] ? (~s + 1'b1) : s;
		res_2x = curve(mag, `AUDIO_W'(`COMP1_X), `AUDIO_W'(`COMP1_A),
			`AUDIO_W'(`COMP1_F), `AUDIO_W'(`COMP1_B));
		res_4x = curve(mag, `AUDIO_W'(`COMP2_X), `AUDIO_W'(`COMP2_A),
			`AUDIO_W'(`COMP2_F), `AUDIO_W'(`COMP2_B));
		res = use_4x ? res_4x : res_2x;
		compress = s[`AUDIO_W-1] ? (~res + 1'b1) : res;
	endfunction

	// Stage 4 register, drives the outputs directly
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (in.mode.master_boost == 2'd0) begin
			audio_l <= in.left;
			audio_r <= in.right;
		end else begin
			// Bit 1 picks the 4x curve
			audio_l <= compress(in.left, in.mode.master_boost[1]);
			audio_r <= compress(in.right, in.mode.master_boost[1]);
		end
	end

	// Sign survives compression, except for the two edge codes
	a_sign_l: assert property (
		@(posedge clk_sys) disable iff (reset)
		(in.left != '0 && in.left != {1'b1, {(`AUDIO_W-1){1'b0}}})
		|=> (audio_l[`AUDIO_W-1] == $past(in.left[`AUDIO_W-1]))
	) else $error("audio_compress: audio_l sign flipped");

	a_sign_r: assert property (
		@(posedge clk_sys) disable iff (reset)
		(in.right != '0 && in.right != {1'b1, {(`AUDIO_W-1){1'b0}}})
		|=> (audio_r[`AUDIO_W-1] == $past(in.right[`AUDIO_W-1]))
	) else $error("audio_compress: audio_r sign flipped");

endmodule

//--- source/audio_level.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_level (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  audio_pkg::sum_sample_t  in,
	output audio_pkg::level_sample_t out
);

	// 5/4 headroom scale unless CD boost already doubled the CD part,
	// then keep the upper 16 bits of the accumulator
	function automatic logic signed [`AUDIO_W-1:0] level(
		input logic signed [`AUDIO_ACC_W-1:0] sum,
		input logic                           cd_boost
	);
		logic signed [`AUDIO_ACC_W-1:0] scaled;
		scaled = cd_boost ? sum : sum + (sum >>> 2);
		level = scaled[`AUDIO_ACC_W-1:`AUDIO_ACC_W-`AUDIO_W];
	endfunction

	//////////////////////////////////////////////////
	// Stage 3 register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out <= '0;
		end else begin
			out.left  <= level(in.left, in.mode.cd_boost);
			out.right <= level(in.right, in.mode.cd_boost);
			out.mode  <= in.mode;
		end
	end

endmodule

//--- source/audio_mixer.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_mixer (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic signed [`AUDIO_W-1:0] cdda_l,
	input  logic signed [`AUDIO_W-1:0] cdda_r,
	input  logic signed [`AUDIO_W-1:0] psg_l,
	input  logic signed [`AUDIO_W-1:0] psg_r,
	input  logic signed [`AUDIO_W-1:0] adpcm,
	input  logic                      cd_boost,
	input  logic [1:0]                master_boost,
	output logic signed [`AUDIO_W-1:0] audio_l,
	output logic signed [`AUDIO_W-1:0] audio_r
);

	audio_pkg::src_sample_t   src;
	audio_pkg::mix_mode_t     mode;
	audio_pkg::atten_sample_t atten;
	audio_pkg::sum_sample_t   sum;
	audio_pkg::level_sample_t level;

	// Pack the core sources
	assign src.cdda_l = cdda_l;
	assign src.cdda_r = cdda_r;
	assign src.psg_l  = psg_l;
	assign src.psg_r  = psg_r;
	assign src.adpcm  = adpcm;

	assign mode.cd_boost     = cd_boost;
	assign mode.master_boost = master_boost;

	//////////////////////////////////////////////////
	// Four stage chain
	//////////////////////////////////////////////////

	audio_attenuate u_audio_attenuate (
		.clk_sys (clk_sys),
		.reset   (reset),
		.src     (src),
		.mode    (mode),
		.out     (atten)
	);

	audio_sum u_audio_sum (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in      (atten),
		.out     (sum)
	);

	audio_level u_audio_level (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in      (sum),
		.out     (level)
	);

	audio_compress u_audio_compress (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in      (level),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

//--- source/audio_pkg.sv
`include "audio_defines.svh"

package audio_pkg;

	// Per-sample mode, travels with the sample
	typedef struct packed {
		logic       cd_boost;
		logic [1:0] master_boost;
	} mix_mode_t;

	// Raw sources from the core
	typedef struct packed {
		logic signed [`AUDIO_W-1:0] cdda_l;
		logic signed [`AUDIO_W-1:0] cdda_r;
		logic signed [`AUDIO_W-1:0] psg_l;
		logic signed [`AUDIO_W-1:0] psg_r;
		logic signed [`AUDIO_W-1:0] adpcm;
	} src_sample_t;

	// After PSG and ADPCM attenuation
	typedef struct packed {
		logic signed [`AUDIO_W-1:0] cdda_l;
		logic signed [`AUDIO_W-1:0] cdda_r;
		logic signed [`AUDIO_W-1:0] psg_l;
		logic signed [`AUDIO_W-1:0] psg_r;
		logic signed [`AUDIO_W-1:0] adpcm;
		mix_mode_t                  mode;
	} atten_sample_t;

	// Wide stereo sum
	typedef struct packed {
		logic signed [`AUDIO_ACC_W-1:0] left;
		logic signed [`AUDIO_ACC_W-1:0] right;
		mix_mode_t                      mode;
	} sum_sample_t;

	// Leveled 16-bit stereo, ready for the compressor
	typedef struct packed {
		logic signed [`AUDIO_W-1:0] left;
		logic signed [`AUDIO_W-1:0] right;
		mix_mode_t                  mode;
	} level_sample_t;

endpackage

//--- source/audio_sum.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module audio_sum (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  audio_pkg::atten_sample_t in,
	output audio_pkg::sum_sample_t   out
);

	// Sign extend one source into the accumulator width
	function automatic logic signed [`AUDIO_ACC_W-1:0] ext(
		input logic signed [`AUDIO_W-1:0] s
	);
		ext = {{(`AUDIO_ACC_W - `AUDIO_W){s[`AUDIO_W-1]}}, s};
	endfunction

	// One side of the mix, CD counted twice under boost
	function automatic logic signed [`AUDIO_ACC_W-1:0] mix(
		input logic signed [`AUDIO_W-1:0] cdda,
		input logic signed [`AUDIO_W-1:0] psg,
		input logic signed [`AUDIO_W-1:0] adpcm,
		input logic                       cd_boost
	);
		logic signed [`AUDIO_ACC_W-1:0] cd_twice;
		cd_twice = cd_boost ? ext(cdda) : '0;
		mix = ext(cdda) + ext(psg) + ext(adpcm) + cd_twice;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out <= '0;
		end else begin
			out.left  <= mix(in.cdda_l, in.psg_l, in.adpcm, in.mode.cd_boost);
			out.right <= mix(in.cdda_r, in.psg_r, in.adpcm, in.mode.cd_boost);
			out.mode  <= in.mode;
		end
	end

	// Master boost 3 is not a defined setting
	a_master_boost_valid: assert property (
		@(posedge clk_sys) disable iff (reset)
		in.mode.master_boost != 2'd3
	) else $error("audio_sum: master_boost reached 3 in the pipeline");

endmodule

//--- tb/tb_audio_mixer.sv
`timescale 1ns/1ps
`include "audio_defines.svh"

module tb_audio_mixer;

	localparam int drive_delay    = 5;
	localparam int reset_timeout  = 50;
	localparam int random_count   = 200;
	localparam int boost_count    = 50;
	localparam int curve_count    = 40;
	localparam int mode_mix_count = 300;
	localparam int last           = `MIX_LATENCY - 1;

	logic                       clk_sys;
	logic                       reset;
	audio_pkg::src_sample_t     stim;
	audio_pkg::mix_mode_t       stim_mode;
	logic signed [`AUDIO_W-1:0] audio_l;
	logic signed [`AUDIO_W-1:0] audio_r;

	// Inputs seen by the DUT over the last four edges
	audio_pkg::src_sample_t     hist_src [0:last];
	audio_pkg::mix_mode_t       hist_mode [0:last];
	logic [last:0]              rst_hist;
	logic signed [`AUDIO_W-1:0] exp_l;
	logic signed [`AUDIO_W-1:0] exp_r;
	logic                       check_on = 1'b0;
	int                         checks_done = 0;
	int                         driven = 0;
	integer                     seed;

	tb_clock #(
		.period_ns    (100),
		.reset_cycles (8),
		.drive_delay  (drive_delay)
	) u_tb_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	audio_mixer u_audio_mixer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cdda_l       (stim.cdda_l),
		.cdda_r       (stim.cdda_r),
		.psg_l        (stim.psg_l),
		.psg_r        (stim.psg_r),
		.adpcm        (stim.adpcm),
		.cd_boost     (stim_mode.cd_boost),
		.master_boost (stim_mode.master_boost),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic integer sign_extend(input logic signed [`AUDIO_W-1:0] s);
		sign_extend = {{(32 - `AUDIO_W){s[`AUDIO_W-1]}}, s};
	endfunction

	// One output channel from one set of inputs
	function automatic logic [`AUDIO_W-1:0] reference_mix(
		input logic signed [`AUDIO_W-1:0] cdda,
		input logic signed [`AUDIO_W-1:0] psg,
		input logic signed [`AUDIO_W-1:0] adpcm,
		input audio_pkg::mix_mode_t       mode
	);
		integer cd;
		integer p;
		integer a;
		integer total;
		integer lvl;
		integer mag;
		integer knee;
		integer gain;
		integer slope;
		integer base;
		integer r;
		cd = sign_extend(cdda);
		p = sign_extend(psg);
		p = (p >>> 1) + (p >>> 2) + (p >>> 4);
		a = sign_extend(adpcm);
		a = (a >>> 1) + (a >>> 2) + (a >>> 3);
		total = cd + p + a;
		if (mode.cd_boost)
			total = total + cd;
		else
			total = total + (total >>> 2);
		// Top 16 of 18 bits
		lvl = total >>> 2;
		if (mode.master_boost == 2'd0) begin
			r = lvl;
		end else begin
			if (mode.master_boost[1]) begin
				knee  = `COMP2_X;
				gain  = `COMP2_A;
				slope = `COMP2_F;
				base  = `COMP2_B;
			end else begin
				knee  = `COMP1_X;
				gain  = `COMP1_A;
				slope = `COMP1_F;
				base  = `COMP1_B;
			end
			mag = (lvl < 0) ? -lvl : lvl;
			r = (mag < knee) ? mag * gain : (mag - knee) / slope + base;
			if (lvl < 0)
				r = -r;
		end
		reference_mix = r[`AUDIO_W-1:0];
	endfunction

	always @(posedge clk_sys) begin
		hist_src[0]  <= stim;
		hist_mode[0] <= stim_mode;
		for (int k = 1; k <= last; k++) begin
			hist_src[k]  <= hist_src[k-1];
			hist_mode[k] <= hist_mode[k-1];
		end
		rst_hist <= {rst_hist[last-1:0], reset};
		if (reset)
			check_on <= 1'b1;
	end

	// Any reset inside the window wipes the sample in flight
	always_comb begin
		if (|rst_hist) begin
			exp_l = '0;
			exp_r = '0;
		end else begin
			exp_l = reference_mix(hist_src[last].cdda_l, hist_src[last].psg_l,
				hist_src[last].adpcm, hist_mode[last]);
			exp_r = reference_mix(hist_src[last].cdda_r, hist_src[last].psg_r,
				hist_src[last].adpcm, hist_mode[last]);
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_audio_l_match: assert property (
		@(posedge clk_sys) check_on |-> (audio_l == exp_l)
	) checks_done = checks_done + 1;
	else begin
		$display("ERROR audio_l expected 0x%h actual 0x%h",
			$sampled(exp_l), $sampled(audio_l));
		$display("TESTBENCH FAILED");
		$fatal(1, "audio_l mismatch");
	end

	a_audio_r_match: assert property (
		@(posedge clk_sys) check_on |-> (audio_r == exp_r)
	) else begin
		$display("ERROR audio_r expected 0x%h actual 0x%h",
			$sampled(exp_r), $sampled(audio_r));
		$display("TESTBENCH FAILED");
		$fatal(1, "audio_r mismatch");
	end

	a_zero_after_reset: assert property (
		@(posedge clk_sys) $fell(reset) |-> (audio_l == '0 && audio_r == '0)
	) else begin
		$display("ERROR audio_l 0x%h audio_r 0x%h after reset, expected 0x0000",
			$sampled(audio_l), $sampled(audio_r));
		$display("TESTBENCH FAILED");
		$fatal(1, "outputs not cleared by reset");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic drive_sample(
		input audio_pkg::src_sample_t s,
		input audio_pkg::mix_mode_t   m
	);
		@(posedge clk_sys);
		#drive_delay;
		stim      = s;
		stim_mode = m;
		driven    = driven + 1;
	endtask

	task automatic random_sample(output audio_pkg::src_sample_t s);
		logic [31:0] rnd;
		rnd = $random(seed);
		s.cdda_l = rnd[15:0];
		s.cdda_r = rnd[31:16];
		rnd = $random(seed);
		s.psg_l = rnd[15:0];
		s.psg_r = rnd[31:16];
		rnd = $random(seed);
		s.adpcm = rnd[15:0];
	endtask

	function automatic audio_pkg::mix_mode_t make_mode(input logic cd, input logic [1:0] mb);
		make_mode.cd_boost     = cd;
		make_mode.master_boost = mb;
	endfunction

	// Only CD audio with everything else silent
	function automatic audio_pkg::src_sample_t cd_only(
		input logic [31:0] l,
		input logic [31:0] r
	);
		cd_only        = '0;
		cd_only.cdda_l = l[15:0];
		cd_only.cdda_r = r[15:0];
	endfunction

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
		end while (reset && cycles < reset_timeout);
		if (reset) begin
			$display("Reset was not released within %0d cycles", reset_timeout);
			$display("TESTBENCH FAILED");
			$fatal(1, "reset timeout");
		end
	endtask

	task automatic run_random(input int count, input audio_pkg::mix_mode_t m);
		audio_pkg::src_sample_t s;
		for (int i = 0; i < count; i++) begin
			random_sample(s);
			drive_sample(s, m);
		end
	endtask

	// Full scale CD under boost followed by a random stream
	task automatic run_cd_boost();
		drive_sample(cd_only(32767, -32768), make_mode(1'b1, 2'd0));
		drive_sample(cd_only(-32768, 32767), make_mode(1'b1, 2'd0));
		drive_sample(cd_only(16384, -1), make_mode(1'b1, 2'd0));
		run_random(boost_count, make_mode(1'b1, 2'd0));
	endtask

	// CD under boost lands at half its value after leveling
	task automatic run_knees(input logic [1:0] mb);
		int knee_cd [0:5];
		knee_cd = '{28086, 28088, 32767, 14798, 14800, 2000};
		for (int k = 0; k < 6; k++) begin
			drive_sample(cd_only(knee_cd[k], -knee_cd[k]), make_mode(1'b1, mb));
			drive_sample(cd_only(-knee_cd[k], knee_cd[k]), make_mode(1'b1, mb));
		end
		run_random(curve_count, make_mode(1'b0, mb));
	endtask

	task automatic run_mode_toggle();
		audio_pkg::src_sample_t s;
		logic [31:0]            rnd;
		for (int i = 0; i < mode_mix_count; i++) begin
			random_sample(s);
			rnd = {$random(seed)} % 32'd3;
			drive_sample(s, make_mode(~i[0], rnd[1:0]));
		end
	endtask

	initial begin
		seed      = 47650;
		// Nonzero inputs while reset holds the pipeline clear
		stim      = {5{16'h4321}};
		stim_mode = '0;
		wait_reset_release();
		// Silent samples ahead of the random streams
		for (int i = 0; i < 4; i++)
			drive_sample('0, make_mode(1'b0, 2'd0));
		run_random(random_count, make_mode(1'b0, 2'd0));
		run_cd_boost();
		run_knees(2'd1);
		run_knees(2'd2);
		run_mode_toggle();
		// Drain the pipeline
		for (int i = 0; i <= `MIX_LATENCY; i++)
			drive_sample('0, make_mode(1'b0, 2'd0));
		if (checks_done < driven) begin
			$display("Only %0d output checks ran for %0d samples", checks_done, driven);
			$display("TESTBENCH FAILED");
			$fatal(1, "output checks missing");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 8,
	parameter int drive_delay  = 5
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(period_ns / 2) clk_sys = ~clk_sys;
	end

	// Reset released just after a rising edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		#drive_delay;
		reset = 1'b0;
	end

endmodule
